// File: rtl/l15_proto_pkg.sv
/*
 * L1.5 protocol definitions
 * widths, request/return type codes, size codes and the
 * return packet as seen on the L1.5 side of the adapter.
 * the L1.5 is big endian, so the byte swap helper lives here too
 */

package l15_proto_pkg;

  //////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////

  // physical address
  localparam int unsigned l15_addr_w     = 40;
  // one bus word
  localparam int unsigned l15_word_w     = 64;
  // transaction id, carried in the thread id field
  localparam int unsigned l15_tid_w      = 2;
  // data words in one return packet
  localparam int unsigned l15_rtrn_words = 4;

  //////////////////////////////////////////////////
  // encodings
  //////////////////////////////////////////////////

  // request types towards the L1.5
  typedef enum logic [4:0] {
    l15_load_rq  = 5'b00000,
    l15_store_rq = 5'b00001,
    l15_imiss_rq = 5'b10000
  } l15_rqtype_e;

  // return types, every other code is unsupported
  typedef enum logic [3:0] {
    l15_load_ret  = 4'b0000,
    l15_ifill_ret = 4'b0001,
    l15_st_ack    = 4'b0100
  } l15_rettype_e;

  // transfer size
  typedef enum logic [2:0] {
    l15_size_byte   = 3'd0,
    l15_size_half   = 3'd1,
    l15_size_word   = 3'd2,
    l15_size_double = 3'd3,
    // full cache line fill
    l15_size_line   = 3'd7
  } l15_size_e;

  // return packet, word 0 in the low bits
  typedef struct packed {
    l15_rettype_e                               rettype;
    logic [l15_tid_w-1:0]                       tid;
    logic [l15_rtrn_words-1:0][l15_word_w-1:0]  data;
  } l15_rtrn_t;

  // byte k of a word moves to byte 7-k
  function automatic logic [l15_word_w-1:0] swap_bytes(input logic [l15_word_w-1:0] w);
    logic [l15_word_w-1:0] r;
    for (int k = 0; k < l15_word_w / 8; k++) begin
      r[8*k +: 8] = w[8*(l15_word_w/8 - 1 - k) +: 8];
    end
    return r;
  endfunction

endpackage

// File: rtl/l1_cache_pkg.sv
/*
 * L1 cache side definitions
 * request structs of the instruction and data cache, their
 * request/return type codes, return widths and queue depths
 */

package l1_cache_pkg;

  //////////////////////////////////////////////////
  // depths and widths
  //////////////////////////////////////////////////

  // per cache request queue
  localparam int unsigned req_fifo_depth  = 2;
  // return packet buffer
  localparam int unsigned rtrn_fifo_depth = 2;
  // instruction fill, four bus words
  localparam int unsigned icache_line_w   = 256;
  // data return, two bus words
  localparam int unsigned dcache_rtrn_w   = 128;

  //////////////////////////////////////////////////
  // encodings and request payloads
  //////////////////////////////////////////////////

  // data cache request type
  typedef enum logic {
    dcache_load_req  = 1'b0,
    dcache_store_req = 1'b1
  } dcache_rtype_e;

  // data cache return type
  typedef enum logic {
    dcache_load_ack  = 1'b0,
    dcache_store_ack = 1'b1
  } dcache_rtrn_e;

  // instruction fill request
  typedef struct packed {
    logic [l15_proto_pkg::l15_addr_w-1:0] paddr;
    // nc fills are 4 bytes only
    logic                                 nc;
    logic [l15_proto_pkg::l15_tid_w-1:0]  tid;
  } icache_req_t;

  // data load/store request, data in little endian
  typedef struct packed {
    dcache_rtype_e                        rtype;
    logic [l15_proto_pkg::l15_addr_w-1:0] paddr;
    l15_proto_pkg::l15_size_e             size;
    logic                                 nc;
    logic [l15_proto_pkg::l15_tid_w-1:0]  tid;
    logic [l15_proto_pkg::l15_word_w-1:0] data;
  } dcache_req_t;

endpackage

// File: rtl/pkt_fifo.sv
/*
 * packet FIFO
 * small circular buffer with a type parameter for the payload.
 * data pushed at an edge shows at the head in the next cycle.
 * push while full and pop while empty are dropped
 */

`timescale 1ns/1ps

module pkt_fifo #(
  parameter type         payload_t = l15_proto_pkg::l15_rtrn_t,
  parameter int unsigned depth     = l1_cache_pkg::rtrn_fifo_depth
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     push_i,
  input  payload_t data_i,
  input  logic     pop_i,
  output payload_t data_o,
  output logic     full_o,
  output logic     empty_o
);

  // pointer and occupancy widths
  localparam int unsigned ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int unsigned cnt_w = $clog2(depth + 1);

  payload_t          mem_q [depth];
  logic [ptr_w-1:0]  rd_ptr_q;
  logic [ptr_w-1:0]  wr_ptr_q;
  logic [cnt_w-1:0]  cnt_q;
  logic              do_push;
  logic              do_pop;

  // wrap at depth, depth need not be a power of two
  function automatic logic [ptr_w-1:0] ptr_next(input logic [ptr_w-1:0] p);
    if (p == ptr_w'(depth - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  assign full_o  = (cnt_q == cnt_w'(depth));
  assign empty_o = (cnt_q == '0);

  // qualified handshakes
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  // head of the queue
  assign data_o = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      // occupancy only moves on a lone push or pop
      case ({do_push, do_pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

// File: rtl/l15_req_arbiter.sv
/*
 * L1.5 request arbiter
 * round-robin between the instruction and data cache queues,
 * grant locked from first valid until the L1.5 ack.
 * encodes request type and size, byte-swaps store data
 */

`timescale 1ns/1ps

module l15_req_arbiter (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  // instruction cache queue head
  input  logic                                 ic_valid_i,
  input  l1_cache_pkg::icache_req_t            ic_req_i,
  output logic                                 ic_pop_o,
  // data cache queue head
  input  logic                                 dc_valid_i,
  input  l1_cache_pkg::dcache_req_t            dc_req_i,
  output logic                                 dc_pop_o,
  // L1.5 request channel
  input  logic                                 l15_ack_i,
  output logic                                 l15_val_o,
  output l15_proto_pkg::l15_rqtype_e           l15_rqtype_o,
  output logic                                 l15_nc_o,
  output l15_proto_pkg::l15_size_e             l15_size_o,
  output logic [l15_proto_pkg::l15_tid_w-1:0]  l15_tid_o,
  output logic [l15_proto_pkg::l15_addr_w-1:0] l15_addr_o,
  output logic [l15_proto_pkg::l15_word_w-1:0] l15_data_o
);

  import l15_proto_pkg::*;
  import l1_cache_pkg::*;

  // source index, 0 = icache, 1 = dcache
  logic sel;
  // preferred source when both are waiting
  logic rr_q;
  // grant held until ack
  logic lock_q;
  logic lock_src_q;

  //////////////////////////////////////////////////
  // grant
  //////////////////////////////////////////////////

  always_comb begin
    if (lock_q) begin
      sel = lock_src_q;
    end else if (ic_valid_i && dc_valid_i) begin
      sel = rr_q;
    end else begin
      // single requester or idle
      sel = dc_valid_i;
    end
  end

  assign l15_val_o = ic_valid_i | dc_valid_i;

  // the granted queue pops on ack
  assign ic_pop_o = l15_val_o & l15_ack_i & ~sel;
  assign dc_pop_o = l15_val_o & l15_ack_i & sel;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rr_q       <= 1'b0;
      lock_q     <= 1'b0;
      lock_src_q <= 1'b0;
    end else if (l15_val_o && l15_ack_i) begin
      // release and hand priority to the other side
      lock_q <= 1'b0;
      rr_q   <= ~sel;
    end else if (l15_val_o) begin
      // waiting for ack, freeze the grant
      lock_q     <= 1'b1;
      lock_src_q <= sel;
    end
  end

  //////////////////////////////////////////////////
  // field mux and encoding
  //////////////////////////////////////////////////

  always_comb begin
    l15_rqtype_o = l15_imiss_rq;
    l15_nc_o     = ic_req_i.nc;
    // icache fills are a full line, or 4 bytes when nc
    l15_size_o   = ic_req_i.nc ? l15_size_word : l15_size_line;
    l15_tid_o    = ic_req_i.tid;
    l15_addr_o   = ic_req_i.paddr;
    l15_data_o   = '0;
    if (sel) begin
      case (dc_req_i.rtype)
        dcache_store_req: l15_rqtype_o = l15_store_rq;
        dcache_load_req:  l15_rqtype_o = l15_load_rq;
        default:          l15_rqtype_o = l15_load_rq;
      endcase
      l15_nc_o   = dc_req_i.nc;
      l15_size_o = dc_req_i.size;
      l15_tid_o  = dc_req_i.tid;
      l15_addr_o = dc_req_i.paddr;
      // L1.5 is big endian
      l15_data_o = swap_bytes(dc_req_i.data);
    end
  end

endmodule

// File: rtl/l15_rtrn_decoder.sv
/*
 * L1.5 return decoder
 * steers the buffered return packet to the instruction or data
 * cache and swaps each returned word back to little endian.
 * unsupported return types raise no valid
 */

`timescale 1ns/1ps

module l15_rtrn_decoder (
  input  logic                                    valid_i,
  input  l15_proto_pkg::l15_rtrn_t                pkt_i,
  // instruction cache return
  output logic                                    ic_vld_o,
  output logic [l15_proto_pkg::l15_tid_w-1:0]     ic_tid_o,
  output logic [l1_cache_pkg::icache_line_w-1:0]  ic_data_o,
  // data cache return
  output logic                                    dc_vld_o,
  output l1_cache_pkg::dcache_rtrn_e              dc_type_o,
  output logic [l15_proto_pkg::l15_tid_w-1:0]     dc_tid_o,
  output logic [l1_cache_pkg::dcache_rtrn_w-1:0]  dc_data_o
);

  import l15_proto_pkg::*;
  import l1_cache_pkg::*;

  //////////////////////////////////////////////////
  // type decode
  //////////////////////////////////////////////////

  always_comb begin
    ic_vld_o  = 1'b0;
    dc_vld_o  = 1'b0;
    dc_type_o = dcache_load_ack;
    if (valid_i) begin
      case (pkt_i.rettype)
        l15_load_ret: begin
          dc_vld_o  = 1'b1;
          dc_type_o = dcache_load_ack;
        end
        l15_st_ack: begin
          dc_vld_o  = 1'b1;
          dc_type_o = dcache_store_ack;
        end
        l15_ifill_ret: begin
          ic_vld_o = 1'b1;
        end
        // anything else is dropped here
        default: begin
          ic_vld_o = 1'b0;
          dc_vld_o = 1'b0;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////
  // payload
  //////////////////////////////////////////////////

  // tid goes back unchanged to both sides
  assign ic_tid_o = pkt_i.tid;
  assign dc_tid_o = pkt_i.tid;

  // data cache gets words 1:0, word 0 low
  assign dc_data_o = {swap_bytes(pkt_i.data[1]), swap_bytes(pkt_i.data[0])};

  // full line for the instruction cache
  always_comb begin
    for (int w = 0; w < l15_rtrn_words; w++) begin
      ic_data_o[w*l15_word_w +: l15_word_w] = swap_bytes(pkt_i.data[w]);
    end
  end

endmodule

// File: rtl/l15_adapter.sv
/*
 * L1 to L1.5 adapter
 * queues instruction and data cache requests, arbitrates them
 * onto the L1.5 request channel, buffers L1.5 returns and
 * routes them back to the caches, which take them at once
 */

`timescale 1ns/1ps

module l15_adapter (
  input  logic                                      clk_i,
  input  logic                                      rst_n_i,
  // instruction cache requests
  input  logic                                      icache_req_i,
  output logic                                      icache_ack_o,
  input  logic [l15_proto_pkg::l15_addr_w-1:0]      icache_paddr_i,
  input  logic                                      icache_nc_i,
  input  logic [l15_proto_pkg::l15_tid_w-1:0]       icache_tid_i,
  // data cache requests
  input  logic                                      dcache_req_i,
  output logic                                      dcache_ack_o,
  input  l1_cache_pkg::dcache_rtype_e               dcache_rtype_i,
  input  logic [l15_proto_pkg::l15_addr_w-1:0]      dcache_paddr_i,
  input  l15_proto_pkg::l15_size_e                  dcache_size_i,
  input  logic                                      dcache_nc_i,
  input  logic [l15_proto_pkg::l15_tid_w-1:0]       dcache_tid_i,
  input  logic [l15_proto_pkg::l15_word_w-1:0]      dcache_data_i,
  // instruction cache returns
  output logic                                      icache_rtrn_vld_o,
  output logic [l15_proto_pkg::l15_tid_w-1:0]       icache_rtrn_tid_o,
  output logic [l1_cache_pkg::icache_line_w-1:0]    icache_rtrn_data_o,
  // data cache returns
  output logic                                      dcache_rtrn_vld_o,
  output l1_cache_pkg::dcache_rtrn_e                dcache_rtrn_type_o,
  output logic [l15_proto_pkg::l15_tid_w-1:0]       dcache_rtrn_tid_o,
  output logic [l1_cache_pkg::dcache_rtrn_w-1:0]    dcache_rtrn_data_o,
  // L1.5 requests
  output logic                                      l15_val_o,
  output l15_proto_pkg::l15_rqtype_e                l15_rqtype_o,
  output logic                                      l15_nc_o,
  output l15_proto_pkg::l15_size_e                  l15_size_o,
  output logic [l15_proto_pkg::l15_tid_w-1:0]       l15_tid_o,
  output logic [l15_proto_pkg::l15_addr_w-1:0]      l15_addr_o,
  output logic [l15_proto_pkg::l15_word_w-1:0]      l15_data_o,
  input  logic                                      l15_ack_i,
  // L1.5 returns, word 0 low
  input  logic                                      l15_rtrn_val_i,
  input  l15_proto_pkg::l15_rettype_e               l15_rtrn_type_i,
  input  logic [l15_proto_pkg::l15_tid_w-1:0]       l15_rtrn_tid_i,
  input  logic [l15_proto_pkg::l15_rtrn_words*l15_proto_pkg::l15_word_w-1:0] l15_rtrn_data_i,
  output logic                                      l15_req_ack_o
);

  import l15_proto_pkg::*;
  import l1_cache_pkg::*;

  // request queues
  icache_req_t ic_in;
  icache_req_t ic_head;
  logic        ic_full;
  logic        ic_empty;
  logic        ic_pop;
  dcache_req_t dc_in;
  dcache_req_t dc_head;
  logic        dc_full;
  logic        dc_empty;
  logic        dc_pop;

  // return buffer
  l15_rtrn_t   rtrn_in;
  l15_rtrn_t   rtrn_head;
  logic        rtrn_full;
  logic        rtrn_empty;

  //////////////////////////////////////////////////
  // request path
  //////////////////////////////////////////////////

  // ack as soon as the queue has room
  assign icache_ack_o = icache_req_i & ~ic_full;
  assign dcache_ack_o = dcache_req_i & ~dc_full;

  assign ic_in = '{paddr: icache_paddr_i, nc: icache_nc_i, tid: icache_tid_i};

  assign dc_in = '{
    rtype: dcache_rtype_i,
    paddr: dcache_paddr_i,
    size:  dcache_size_i,
    nc:    dcache_nc_i,
    tid:   dcache_tid_i,
    data:  dcache_data_i
  };

  pkt_fifo #(
    .payload_t (icache_req_t),
    .depth     (req_fifo_depth)
  ) i_ic_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (icache_ack_o),
    .data_i  (ic_in),
    .pop_i   (ic_pop),
    .data_o  (ic_head),
    .full_o  (ic_full),
    .empty_o (ic_empty)
  );

  pkt_fifo #(
    .payload_t (dcache_req_t),
    .depth     (req_fifo_depth)
  ) i_dc_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (dcache_ack_o),
    .data_i  (dc_in),
    .pop_i   (dc_pop),
    .data_o  (dc_head),
    .full_o  (dc_full),
    .empty_o (dc_empty)
  );

  l15_req_arbiter i_req_arbiter (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .ic_valid_i   (~ic_empty),
    .ic_req_i     (ic_head),
    .ic_pop_o     (ic_pop),
    .dc_valid_i   (~dc_empty),
    .dc_req_i     (dc_head),
    .dc_pop_o     (dc_pop),
    .l15_ack_i    (l15_ack_i),
    .l15_val_o    (l15_val_o),
    .l15_rqtype_o (l15_rqtype_o),
    .l15_nc_o     (l15_nc_o),
    .l15_size_o   (l15_size_o),
    .l15_tid_o    (l15_tid_o),
    .l15_addr_o   (l15_addr_o),
    .l15_data_o   (l15_data_o)
  );

  //////////////////////////////////////////////////
  // return path
  //////////////////////////////////////////////////

  // take the packet if the buffer has room
  assign l15_req_ack_o = l15_rtrn_val_i & ~rtrn_full;

  assign rtrn_in = '{rettype: l15_rtrn_type_i, tid: l15_rtrn_tid_i, data: l15_rtrn_data_i};

  // head drains every cycle, the caches cannot stall
  pkt_fifo #(
    .payload_t (l15_rtrn_t),
    .depth     (rtrn_fifo_depth)
  ) i_rtrn_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (l15_req_ack_o),
    .data_i  (rtrn_in),
    .pop_i   (~rtrn_empty),
    .data_o  (rtrn_head),
    .full_o  (rtrn_full),
    .empty_o (rtrn_empty)
  );

  l15_rtrn_decoder i_rtrn_decoder (
    .valid_i   (~rtrn_empty),
    .pkt_i     (rtrn_head),
    .ic_vld_o  (icache_rtrn_vld_o),
    .ic_tid_o  (icache_rtrn_tid_o),
    .ic_data_o (icache_rtrn_data_o),
    .dc_vld_o  (dcache_rtrn_vld_o),
    .dc_type_o (dcache_rtrn_type_o),
    .dc_tid_o  (dcache_rtrn_tid_o),
    .dc_data_o (dcache_rtrn_data_o)
  );

endmodule

// File: verif/l15_adapter_chk.sv
/*
 * protocol assertions for the L1.5 adapter
 * request hold until ack, return routing and latency,
 * output state right after reset
 */

`timescale 1ns/1ps

module l15_adapter_chk (
  input logic                         clk_i,
  input logic                         rst_n_i,
  input logic                         icache_req_i,
  input logic                         icache_ack_o,
  input logic                         dcache_req_i,
  input logic                         dcache_ack_o,
  input logic                         l15_val_o,
  input l15_proto_pkg::l15_rqtype_e   l15_rqtype_o,
  input logic                         l15_nc_o,
  input l15_proto_pkg::l15_size_e     l15_size_o,
  input logic [1:0]                   l15_tid_o,
  input logic [39:0]                  l15_addr_o,
  input logic [63:0]                  l15_data_o,
  input logic                         l15_ack_i,
  input logic                         l15_rtrn_val_i,
  input l15_proto_pkg::l15_rettype_e  l15_rtrn_type_i,
  input logic                         l15_req_ack_o,
  input logic                         icache_rtrn_vld_o,
  input logic                         dcache_rtrn_vld_o
);

  import l15_proto_pkg::*;

  logic supported;
  assign supported = (l15_rtrn_type_i == l15_load_ret) || (l15_rtrn_type_i == l15_st_ack) ||
                     (l15_rtrn_type_i == l15_ifill_ret);

  // request channel frozen until the L1.5 acks
  a_req_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    l15_val_o && !l15_ack_i |=> l15_val_o && $stable(l15_rqtype_o) && $stable(l15_nc_o) &&
      $stable(l15_size_o) && $stable(l15_tid_o) && $stable(l15_addr_o) && $stable(l15_data_o))
    else $error("request fields changed before ack");

  a_one_vld: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(icache_rtrn_vld_o && dcache_rtrn_vld_o))
    else $error("both return valids high");

  a_ack_val: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    l15_req_ack_o |-> l15_rtrn_val_i)
    else $error("return ack without return valid");

  ////////////////////////////////////////////////
  // return latency, exactly one cycle
  ////////////////////////////////////////////////

  a_rtrn_lat: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    l15_req_ack_o && supported |=> icache_rtrn_vld_o || dcache_rtrn_vld_o)
    else $error("accepted return gave no cache valid");

  a_rtrn_drop: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    l15_req_ack_o && !supported |=> !icache_rtrn_vld_o && !dcache_rtrn_vld_o)
    else $error("unsupported return reached a cache");

  a_vld_src: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    icache_rtrn_vld_o || dcache_rtrn_vld_o |-> $past(l15_req_ack_o))
    else $error("cache valid without a return accepted the cycle before");

  // first cycle out of reset
  a_reset: assert property (@(posedge clk_i)
    $rose(rst_n_i) |-> !l15_val_o && !l15_req_ack_o && !icache_rtrn_vld_o &&
      !dcache_rtrn_vld_o && (!icache_ack_o || icache_req_i) && (!dcache_ack_o || dcache_req_i))
    else $error("outputs not idle after reset");

endmodule

// File: verif/tb_l15_adapter.sv
/*
 * testbench for the L1 to L1.5 adapter
 * drives both cache request ports, models the L1.5 side and
 * checks requests and returns against values built from the
 * protocol rules
 */

`timescale 1ns/1ps

module tb_l15_adapter;

  import l15_proto_pkg::*;
  import l1_cache_pkg::*;

  // cycles allowed for any single wait
  localparam int unsigned tmo = 200;

  // expected L1.5 request
  typedef struct packed {
    l15_rqtype_e          rq;
    logic                 nc;
    l15_size_e            size;
    logic [1:0]           tid;
    logic [39:0]          addr;
    logic [63:0]          data;
  } req_exp_t;

  // expected cache return
  typedef struct packed {
    logic                 st;
    logic [1:0]           tid;
    logic [255:0]         data;
  } rtrn_exp_t;

  logic                 clk_i;
  logic                 rst_n_i;
  logic                 icache_req_i;
  logic                 icache_ack_o;
  logic [39:0]          icache_paddr_i;
  logic                 icache_nc_i;
  logic [1:0]           icache_tid_i;
  logic                 dcache_req_i;
  logic                 dcache_ack_o;
  dcache_rtype_e        dcache_rtype_i;
  logic [39:0]          dcache_paddr_i;
  l15_size_e            dcache_size_i;
  logic                 dcache_nc_i;
  logic [1:0]           dcache_tid_i;
  logic [63:0]          dcache_data_i;
  logic                 icache_rtrn_vld_o;
  logic [1:0]           icache_rtrn_tid_o;
  logic [255:0]         icache_rtrn_data_o;
  logic                 dcache_rtrn_vld_o;
  dcache_rtrn_e         dcache_rtrn_type_o;
  logic [1:0]           dcache_rtrn_tid_o;
  logic [127:0]         dcache_rtrn_data_o;
  logic                 l15_val_o;
  l15_rqtype_e          l15_rqtype_o;
  logic                 l15_nc_o;
  l15_size_e            l15_size_o;
  logic [1:0]           l15_tid_o;
  logic [39:0]          l15_addr_o;
  logic [63:0]          l15_data_o;
  logic                 l15_ack_i;
  logic                 l15_rtrn_val_i;
  l15_rettype_e         l15_rtrn_type_i;
  logic [1:0]           l15_rtrn_tid_i;
  logic [255:0]         l15_rtrn_data_i;
  logic                 l15_req_ack_o;

  int          errors;
  int          timeouts;
  integer      seed = 32'h806e;
  logic        ack_en;
  logic        prev_both;
  logic        prev_ic;
  req_exp_t    ic_exp[$];
  req_exp_t    dc_exp[$];
  rtrn_exp_t   ic_rq[$];
  rtrn_exp_t   dc_rq[$];

  l15_adapter dut (.*);

  bind l15_adapter l15_adapter_chk i_chk (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // big endian word where byte k goes to byte 7-k
  function automatic logic [63:0] rev_bytes(input logic [63:0] w);
    return {<<8{w}};
  endfunction

  task automatic fail_val(input string name, input logic [255:0] got, input logic [255:0] exp);
    $display("Fail at %0t: %s is %0h, expected %0h", $time, name, got, exp);
    errors++;
  endtask

  //////////////////////////////////////////////////
  // L1.5 model and monitors
  //////////////////////////////////////////////////

  // random ack in one of three cycles while enabled
  always @(posedge clk_i) begin
    l15_ack_i <= ack_en && ($random(seed) % 3 == 0);
  end

  task automatic check_req();
    req_exp_t e;
    logic     is_ic;
    logic     both;
    is_ic = (l15_rqtype_o == l15_imiss_rq);
    both  = (ic_exp.size() > 0) && (dc_exp.size() > 0);
    if ((is_ic && ic_exp.size() == 0) || (!is_ic && dc_exp.size() == 0)) begin
      $display("request on the L1.5 channel that no cache sent, at %0t", $time);
      errors++;
      return;
    end
    e = is_ic ? ic_exp.pop_front() : dc_exp.pop_front();
    assert (l15_rqtype_o == e.rq) else fail_val("l15_rqtype_o", l15_rqtype_o, e.rq);
    assert (l15_nc_o == e.nc) else fail_val("l15_nc_o", l15_nc_o, e.nc);
    assert (l15_size_o == e.size) else fail_val("l15_size_o", l15_size_o, e.size);
    assert (l15_tid_o == e.tid) else fail_val("l15_tid_o", l15_tid_o, e.tid);
    assert (l15_addr_o == e.addr) else fail_val("l15_addr_o", l15_addr_o, e.addr);
    assert (l15_data_o == e.data) else fail_val("l15_data_o", l15_data_o, e.data);
    // with both sources waiting the grant alternates
    if (both && prev_both) begin
      assert (is_ic != prev_ic) else fail_val("l15 grant source", is_ic, !prev_ic);
    end
    prev_both = both;
    prev_ic   = is_ic;
  endtask

  task automatic check_rtrn(input logic is_ic);
    rtrn_exp_t e;
    if ((is_ic && ic_rq.size() == 0) || (!is_ic && dc_rq.size() == 0)) begin
      $display("cache return valid with no packet pending, at %0t", $time);
      errors++;
      return;
    end
    if (is_ic) begin
      e = ic_rq.pop_front();
      assert (icache_rtrn_tid_o == e.tid)
        else fail_val("icache_rtrn_tid_o", icache_rtrn_tid_o, e.tid);
      assert (icache_rtrn_data_o == e.data)
        else fail_val("icache_rtrn_data_o", icache_rtrn_data_o, e.data);
    end else begin
      e = dc_rq.pop_front();
      assert ((dcache_rtrn_type_o == dcache_store_ack) == e.st)
        else fail_val("dcache_rtrn_type_o", dcache_rtrn_type_o, e.st);
      assert (dcache_rtrn_tid_o == e.tid)
        else fail_val("dcache_rtrn_tid_o", dcache_rtrn_tid_o, e.tid);
      assert (dcache_rtrn_data_o == e.data[127:0])
        else fail_val("dcache_rtrn_data_o", dcache_rtrn_data_o, e.data);
    end
  endtask

  always @(posedge clk_i) begin
    if (rst_n_i) begin
      if (l15_val_o && l15_ack_i) begin
        check_req();
      end
      if (icache_rtrn_vld_o) begin
        check_rtrn(1'b1);
      end
      if (dcache_rtrn_vld_o) begin
        check_rtrn(1'b0);
      end
    end
  end

  //////////////////////////////////////////////////
  // cache side drivers
  //////////////////////////////////////////////////

  task automatic new_ic_payload(input logic nc);
    logic [31:0] r1;
    logic [31:0] r2;
    r1 = $random(seed);
    r2 = $random(seed);
    icache_paddr_i <= {r1[7:0], r2};
    icache_nc_i    <= nc;
    icache_tid_i   <= r1[9:8];
  endtask

  task automatic new_dc_payload();
    logic [31:0] r1;
    logic [31:0] r2;
    logic [31:0] r3;
    r1 = $random(seed);
    r2 = $random(seed);
    r3 = $random(seed);
    dcache_rtype_i <= dcache_rtype_e'(r1[12]);
    dcache_paddr_i <= {r1[7:0], r2};
    dcache_size_i  <= l15_size_e'({1'b0, r1[11:10]});
    dcache_nc_i    <= r1[13];
    dcache_tid_i   <= r1[9:8];
    // loads carry no data
    dcache_data_i  <= r1[12] ? {r3, r2} : 64'd0;
  endtask

  // record what the accepted request must look like on the L1.5
  task automatic push_ic_exp();
    req_exp_t e;
    e.rq   = l15_imiss_rq;
    e.nc   = icache_nc_i;
    e.size = icache_nc_i ? l15_size_word : l15_size_line;
    e.tid  = icache_tid_i;
    e.addr = icache_paddr_i;
    e.data = 64'd0;
    ic_exp.push_back(e);
  endtask

  task automatic push_dc_exp();
    req_exp_t e;
    e.rq   = (dcache_rtype_i == dcache_store_req) ? l15_store_rq : l15_load_rq;
    e.nc   = dcache_nc_i;
    e.size = dcache_size_i;
    e.tid  = dcache_tid_i;
    e.addr = dcache_paddr_i;
    e.data = rev_bytes(dcache_data_i);
    dc_exp.push_back(e);
  endtask

  task automatic send_ic(input logic nc);
    int n;
    n = 0;
    new_ic_payload(nc);
    icache_req_i <= 1'b1;
    do begin
      @(posedge clk_i);
      n++;
    end while (!icache_ack_o && n < tmo);
    if (icache_ack_o) begin
      push_ic_exp();
    end else begin
      $display("instruction cache request was never acknowledged");
      timeouts++;
    end
    icache_req_i <= 1'b0;
  endtask

  task automatic send_dc();
    int n;
    n = 0;
    new_dc_payload();
    dcache_req_i <= 1'b1;
    do begin
      @(posedge clk_i);
      n++;
    end while (!dcache_ack_o && n < tmo);
    if (dcache_ack_o) begin
      push_dc_exp();
    end else begin
      $display("data cache request was never acknowledged");
      timeouts++;
    end
    dcache_req_i <= 1'b0;
  endtask

  // both caches keep requesting while the L1.5 stays silent
  task automatic fill_queues();
    int ic_n;
    int dc_n;
    ic_n = 0;
    dc_n = 0;
    new_ic_payload(1'b0);
    new_dc_payload();
    icache_req_i <= 1'b1;
    dcache_req_i <= 1'b1;
    repeat (8) begin
      @(posedge clk_i);
      if (icache_ack_o) begin
        push_ic_exp();
        ic_n++;
        new_ic_payload(1'b0);
      end
      if (dcache_ack_o) begin
        push_dc_exp();
        dc_n++;
        new_dc_payload();
      end
    end
    icache_req_i <= 1'b0;
    dcache_req_i <= 1'b0;
    assert (ic_n == req_fifo_depth) else fail_val("icache_ack_o count", ic_n, req_fifo_depth);
    assert (dc_n == req_fifo_depth) else fail_val("dcache_ack_o count", dc_n, req_fifo_depth);
  endtask

  task automatic wait_drain(input string what);
    int n;
    n = 0;
    while ((ic_exp.size() + dc_exp.size() + ic_rq.size() + dc_rq.size()) != 0 && n < tmo) begin
      @(posedge clk_i);
      n++;
    end
    if (n >= tmo) begin
      $display("%s still pending after %0d cycles", what, tmo);
      timeouts++;
    end
  endtask

  //////////////////////////////////////////////////
  // L1.5 return driver
  //////////////////////////////////////////////////

  task automatic send_rtrn(input l15_rettype_e t);
    logic [255:0] d;
    logic [31:0]  r;
    rtrn_exp_t    e;
    int           n;
    for (int k = 0; k < 8; k++) begin
      r = $random(seed);
      d[32*k +: 32] = r;
    end
    r = $random(seed);
    l15_rtrn_val_i  <= 1'b1;
    l15_rtrn_type_i <= t;
    l15_rtrn_tid_i  <= r[1:0];
    l15_rtrn_data_i <= d;
    n = 0;
    do begin
      @(posedge clk_i);
      n++;
    end while (!l15_req_ack_o && n < tmo);
    if (!l15_req_ack_o) begin
      $display("return packet was never acknowledged");
      timeouts++;
    end else if (t == l15_ifill_ret) begin
      e.st  = 1'b0;
      e.tid = r[1:0];
      for (int w = 0; w < 4; w++) begin
        e.data[64*w +: 64] = rev_bytes(d[64*w +: 64]);
      end
      ic_rq.push_back(e);
    end else if (t == l15_load_ret || t == l15_st_ack) begin
      e.st   = (t == l15_st_ack);
      e.tid  = r[1:0];
      e.data = {128'd0, rev_bytes(d[127:64]), rev_bytes(d[63:0])};
      dc_rq.push_back(e);
    end
    l15_rtrn_val_i <= 1'b0;
  endtask

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial begin
    errors          = 0;
    timeouts        = 0;
    prev_both       = 1'b0;
    prev_ic         = 1'b0;
    ack_en          = 1'b0;
    l15_ack_i       = 1'b0;
    icache_req_i    = 1'b0;
    icache_paddr_i  = '0;
    icache_nc_i     = 1'b0;
    icache_tid_i    = '0;
    dcache_req_i    = 1'b0;
    dcache_rtype_i  = dcache_load_req;
    dcache_paddr_i  = '0;
    dcache_size_i   = l15_size_byte;
    dcache_nc_i     = 1'b0;
    dcache_tid_i    = '0;
    dcache_data_i   = '0;
    l15_rtrn_val_i  = 1'b0;
    l15_rtrn_type_i = l15_load_ret;
    l15_rtrn_tid_i  = '0;
    l15_rtrn_data_i = '0;
    rst_n_i         = 1'b0;
    repeat (10) @(posedge clk_i);
    rst_n_i <= 1'b1;
    repeat (3) @(posedge clk_i);

    // single fills, loads and stores with random ack delay
    ack_en <= 1'b1;
    for (int i = 0; i < 8; i++) begin
      send_ic(i[0]);
      send_dc();
    end
    wait_drain("single requests");

    // hold the ack off and release it with both queues loaded
    ack_en <= 1'b0;
    repeat (2) @(posedge clk_i);
    fill_queues();
    repeat (4) @(posedge clk_i);
    ack_en <= 1'b1;
    wait_drain("queued requests");

    // returns of every kind plus one unsupported code
    send_rtrn(l15_load_ret);
    send_rtrn(l15_ifill_ret);
    send_rtrn(l15_st_ack);
    send_rtrn(l15_rettype_e'(4'hf));
    send_rtrn(l15_ifill_ret);
    send_rtrn(l15_load_ret);
    repeat (3) @(posedge clk_i);
    wait_drain("returns");

    $display("checks done: %0d errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: tb.f
rtl/l15_proto_pkg.sv
rtl/l1_cache_pkg.sv
rtl/pkt_fifo.sv
rtl/l15_req_arbiter.sv
rtl/l15_rtrn_decoder.sv
rtl/l15_adapter.sv
verif/l15_adapter_chk.sv
verif/tb_l15_adapter.sv

// File: run.sh
#!/bin/sh
# build and run the adapter testbench with Verilator, run from the project root
verilator --binary --timing --assert --top-module tb_l15_adapter -f tb.f \
  -Mdir obj_dir > build.log 2>&1 \
  && ./obj_dir/Vtb_l15_adapter > sim.log 2>&1 \
  || { echo "build or simulation failed, see build.log and sim.log"; exit 1; }
grep -q "ERRORS FOUND" sim.log \
  && { echo "simulation reported failures, see sim.log"; exit 1; } \
  || { echo "simulation passed"; exit 0; }
